// File: hdl/serviceProtocol_consts.svh
`ifndef SERVICE_PROTOCOL_CONSTS_SVH
`define SERVICE_PROTOCOL_CONSTS_SVH

// Width of one protocol word.
`define WORD_WIDTH 16

// Endpoint address field, low byte of the first header word.
`define ADDR_WIDTH 8

// Number of command endpoints.
`define NUM_ENDPOINTS 4

// Registers in each endpoint, also the largest data count.
`define REGS_PER_ENDPOINT 4

// Bits needed to index an endpoint or a register.
`define EP_INDEX_WIDTH 2

`endif

// File: hdl/serviceProtocolPkg.sv
`default_nettype none

`include "serviceProtocol_consts.svh"

package serviceProtocolPkg;

	typedef enum logic [7:0] {
		CMD_WRITE   = 8'h01,
		CMD_ADD     = 8'h02,
		CMD_CLEAR   = 8'h03,
		CMD_UNKNOWN = 8'hFF
	} TCommandCode;

	// Type of the last word taken in.
	typedef enum logic [2:0] {IDLE, HEAD1, HEAD2, DATA, CRC, NUM} TDecoderState;

	typedef enum logic [1:0] {
		STATUS_OK,
		STATUS_BAD_CRC,
		STATUS_BAD_CMD,
		STATUS_NO_ENDPOINT
	} TPacketStatus;

	typedef struct packed {
		logic                        valid;
		logic [`NUM_ENDPOINTS-1:0]   select;
		TCommandCode                 cmd;
		logic [`EP_INDEX_WIDTH-1:0]  wordNum;
		logic [`WORD_WIDTH-1:0]      data;
	} TDataStrobe;

	typedef struct packed {
		logic                        valid;
		logic [`NUM_ENDPOINTS-1:0]   select;
		logic [`ADDR_WIDTH-1:0]      addr;
		logic [`WORD_WIDTH-1:0]      num;
		TPacketStatus                status;
	} TPacketDone;

	typedef struct packed {
		logic [`ADDR_WIDTH-1:0]      addr;
		logic [`WORD_WIDTH-1:0]      num;
		TPacketStatus                status;
		logic [`WORD_WIDTH-1:0]      regSum;
	} TReport;

endpackage

`default_nettype wire

// File: hdl/packetDecoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "serviceProtocol_consts.svh"

module packetDecoder (
	input  logic                           clk,
	input  logic                           rstN,
	input  logic                           enable,
	input  logic                           wordValid,
	input  logic [`WORD_WIDTH-1:0]         word,
	output serviceProtocolPkg::TDataStrobe dataStrobe,
	output serviceProtocolPkg::TPacketDone packetDone
);
	import serviceProtocolPkg::*;

	function automatic TCommandCode decodeCmd(input logic [7:0] code);
		case (code)
			CMD_WRITE, CMD_ADD, CMD_CLEAR: return TCommandCode'(code);
			default: return CMD_UNKNOWN;
		endcase
	endfunction

	function automatic logic [`NUM_ENDPOINTS-1:0] toSelect(input logic [`ADDR_WIDTH-1:0] a);
		logic [`NUM_ENDPOINTS-1:0] sel;
		sel = '0;
		if (a < `NUM_ENDPOINTS)
			sel[a[`EP_INDEX_WIDTH-1:0]] = 1'b1;
		return sel;
	endfunction

	TDecoderState state, nextState;

	logic [`ADDR_WIDTH-1:0]    addr;
	logic [`NUM_ENDPOINTS-1:0] addrSelect;
	logic [`WORD_WIDTH-1:0]    checksum;
	logic [7:0]                dataCount;
	logic [7:0]                dataLeft;
	TPacketStatus              pendingStatus;

	// Second header word fields, valid while state is HEAD1.
	TCommandCode headCmd;
	logic [7:0]  headCount;
	logic        headBad;

	assign headCmd = decodeCmd(word[7:0]);
	assign headCount = word[15:8];
	assign headBad = (headCmd == CMD_UNKNOWN) || (headCount > `REGS_PER_ENDPOINT)
		|| ((headCmd == CMD_CLEAR) != (headCount == 8'd0));

	always_comb begin
		nextState = state;
		unique case (state)
			IDLE, NUM: nextState = HEAD1;
			HEAD1: nextState = headBad ? IDLE : HEAD2;
			HEAD2, DATA: nextState = (dataLeft == 8'd0) ? CRC : DATA;
			CRC: nextState = NUM;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstN || !enable) begin
			state <= IDLE;
			dataStrobe.valid <= 1'b0;
			dataStrobe.select <= '0;
			packetDone.valid <= 1'b0;
		end else begin
			dataStrobe.valid <= 1'b0;
			packetDone.valid <= 1'b0;
			if (wordValid) begin
				state <= nextState;
				unique case (state)
					IDLE, NUM: begin
						addr <= word[`ADDR_WIDTH-1:0];
						addrSelect <= toSelect(word[`ADDR_WIDTH-1:0]);
						checksum <= word;
					end
					HEAD1: begin
						checksum <= checksum + word;
						dataCount <= headCount;
						dataLeft <= headCount;
						dataStrobe.select <= addrSelect;
						dataStrobe.cmd <= headCmd;
						// Bad header ends the packet at once.
						if (headBad) begin
							packetDone.valid <= 1'b1;
							packetDone.select <= addrSelect;
							packetDone.addr <= addr;
							packetDone.num <= '0;
							packetDone.status <= STATUS_BAD_CMD;
						end
					end
					HEAD2, DATA: begin
						if (dataLeft == 8'd0) begin
							if (checksum != word)
								pendingStatus <= STATUS_BAD_CRC;
							else if (addrSelect == '0)
								pendingStatus <= STATUS_NO_ENDPOINT;
							else
								pendingStatus <= STATUS_OK;
						end else begin
							checksum <= checksum + word;
							dataLeft <= dataLeft - 8'd1;
							dataStrobe.valid <= 1'b1;
							dataStrobe.wordNum <= `EP_INDEX_WIDTH'(dataCount - dataLeft);
							dataStrobe.data <= word;
						end
					end
					CRC: begin
						packetDone.valid <= 1'b1;
						packetDone.select <= addrSelect;
						packetDone.addr <= addr;
						packetDone.num <= word;
						packetDone.status <= pendingStatus;
					end
				endcase
			end
		end
	end

	assert property (@(posedge clk) disable iff (!rstN)
		dataStrobe.valid |-> $onehot0(dataStrobe.select));

	assert property (@(posedge clk) disable iff (!rstN)
		!(dataStrobe.valid && packetDone.valid));

endmodule

`default_nettype wire

// File: hdl/commandEndpoint.sv
`timescale 1ns/1ps
`default_nettype none

`include "serviceProtocol_consts.svh"

module commandEndpoint #(
	parameter int EP_INDEX = 0
) (
	input  logic                           clk,
	input  logic                           rstN,
	input  serviceProtocolPkg::TDataStrobe dataStrobe,
	input  serviceProtocolPkg::TPacketDone packetDone,
	output logic [`WORD_WIDTH-1:0]         regSum
);
	import serviceProtocolPkg::*;

	logic [`WORD_WIDTH-1:0] regs    [`REGS_PER_ENDPOINT];
	logic [`WORD_WIDTH-1:0] shadows [`REGS_PER_ENDPOINT];
	TCommandCode            pendingCmd;

	logic selected, load, commit;

	assign selected = dataStrobe.select[EP_INDEX];
	assign load = dataStrobe.valid && selected;
	assign commit = packetDone.valid && packetDone.select[EP_INDEX];

	always_ff @(posedge clk) begin
		if (!rstN) begin
			pendingCmd <= CMD_UNKNOWN;
			for (int i = 0; i < `REGS_PER_ENDPOINT; i++) begin
				regs[i] <= '0;
				shadows[i] <= '0;
			end
		end else begin
			if (selected)
				pendingCmd <= dataStrobe.cmd;
			if (load) begin
				if (dataStrobe.cmd == CMD_ADD)
					shadows[dataStrobe.wordNum] <= regs[dataStrobe.wordNum] + dataStrobe.data;
				else
					shadows[dataStrobe.wordNum] <= dataStrobe.data;
			end
			if (commit) begin
				for (int i = 0; i < `REGS_PER_ENDPOINT; i++) begin
					if (packetDone.status != STATUS_OK) begin
						shadows[i] <= regs[i];
					end else if (pendingCmd == CMD_CLEAR) begin
						regs[i] <= '0;
						shadows[i] <= '0;
					end else begin
						regs[i] <= shadows[i];
					end
				end
			end else if (!selected) begin
				// Drop anything staged by an aborted packet.
				for (int i = 0; i < `REGS_PER_ENDPOINT; i++)
					shadows[i] <= regs[i];
			end
		end
	end

	always_comb begin
		regSum = '0;
		for (int i = 0; i < `REGS_PER_ENDPOINT; i++)
			regSum = regSum + regs[i];
	end

	assert property (@(posedge clk) disable iff (!rstN) commit |-> !load);

endmodule

`default_nettype wire

// File: hdl/responseCollector.sv
`timescale 1ns/1ps
`default_nettype none

`include "serviceProtocol_consts.svh"

module responseCollector (
	input  logic                                       clk,
	input  logic                                       rstN,
	input  serviceProtocolPkg::TPacketDone             packetDone,
	input  logic [`NUM_ENDPOINTS-1:0][`WORD_WIDTH-1:0] regSums,
	output serviceProtocolPkg::TReport                 report,
	output logic                                       reportValid,
	output logic [15:0]                                errCount
);
	import serviceProtocolPkg::*;

	// One stage behind packetDone, so the sums are post-commit.
	TPacketDone             doneQ;
	logic [`WORD_WIDTH-1:0] selectedSum;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			doneQ.valid <= 1'b0;
			errCount <= '0;
		end else begin
			doneQ <= packetDone;
			if (packetDone.valid && packetDone.status != STATUS_OK)
				errCount <= errCount + 16'd1;
		end
	end

	// Empty select gives zero.
	always_comb begin
		selectedSum = '0;
		for (int i = 0; i < `NUM_ENDPOINTS; i++) begin
			if (doneQ.select[i])
				selectedSum = selectedSum | regSums[i];
		end
	end

	always_comb begin
		report.addr = doneQ.addr;
		report.num = doneQ.num;
		report.status = doneQ.status;
		report.regSum = selectedSum;
	end

	assign reportValid = doneQ.valid;

	assert property (@(posedge clk) disable iff (!rstN)
		reportValid && report.status == STATUS_NO_ENDPOINT |-> report.regSum == '0);

endmodule

`default_nettype wire

// File: hdl/serviceProtocolTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "serviceProtocol_consts.svh"

module serviceProtocolTop (
	input  logic                       clk,
	input  logic                       rstN,
	input  logic                       enable,
	input  logic                       wordValid,
	input  logic [`WORD_WIDTH-1:0]     word,
	output serviceProtocolPkg::TReport report,
	output logic                       reportValid,
	output logic [15:0]                errCount
);
	import serviceProtocolPkg::*;

	TDataStrobe                                 dataStrobe;
	TPacketDone                                 packetDone;
	logic [`NUM_ENDPOINTS-1:0][`WORD_WIDTH-1:0] regSums;

	packetDecoder decoder (
		.clk, .rstN, .enable, .wordValid, .word,
		.dataStrobe,
		.packetDone
	);

	for (genvar i = 0; i < `NUM_ENDPOINTS; i++) begin : genEndpoint
		commandEndpoint #(.EP_INDEX(i)) endpoint (
			.clk, .rstN,
			.dataStrobe,
			.packetDone,
			.regSum(regSums[i])
		);
	end

	responseCollector collector (
		.clk, .rstN,
		.packetDone,
		.regSums,
		.report, .reportValid, .errCount
	);

endmodule

`default_nettype wire

// File: tb/serviceProtocolTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "serviceProtocol_consts.svh"

module serviceProtocolTb;
	import serviceProtocolPkg::*;

	localparam int VECTOR_DEPTH = 256;
	localparam int MAX_TESTS = 32;
	localparam int CLOCK_PERIOD = 100;

	logic                   clk;
	logic                   rstN;
	logic                   enable;
	logic                   wordValid;
	logic [`WORD_WIDTH-1:0] word;
	TReport                 report;
	logic                   reportValid;
	logic [15:0]            errCount;

	// Flat token memory, laid out as described at the top of the vector file.
	logic [19:0] vectors [VECTOR_DEPTH];

	int          testCount;
	int          testBase [MAX_TESTS];
	int          gapCycles [MAX_TESTS];
	int          watchdogCycles;
	int          passCount;
	int          failCount;
	logic [31:0] lfsr;

	serviceProtocolTop uut (
		.clk, .rstN, .enable, .wordValid, .word,
		.report, .reportValid, .errCount
	);

	initial begin
		clk = 1'b0;
		forever #(CLOCK_PERIOD / 2) clk = ~clk;
	end

	// Fibonacci taps 32, 22, 2, 1.
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic string testName(input logic [19:0] idx);
		case (idx)
			20'h0: return "write";
			20'h1: return "add";
			20'h2: return "clear";
			20'h3: return "rewrite";
			20'h4: return "badCrc";
			20'h5: return "noEndpoint";
			20'h6: return "afterNoEndpoint";
			20'h7: return "badCmd";
			20'h8: return "afterBadCmd";
			20'h9: return "backToBackWrite";
			20'hA: return "backToBackAdd";
			20'hB: return "backToBackClear";
			default: return "unnamed";
		endcase
	endfunction

	function automatic string reportText(input TReport r);
		return $sformatf("addr=%02h num=%04h status=%s regSum=%04h",
			r.addr, r.num, r.status.name(), r.regSum);
	endfunction

	task automatic compareReport(input string name, input TReport expected,
		input TReport actual, output bit ok);
		ok = (actual === expected);
		if (!ok)
			$display("mismatch %s report expected %s actual %s",
				name, reportText(expected), reportText(actual));
	endtask

	task automatic compareCount(input string name, input logic [15:0] expected,
		input logic [15:0] actual, output bit ok);
		ok = (actual === expected);
		if (!ok)
			$display("mismatch %s errCount expected %04h actual %04h", name, expected, actual);
	endtask

	task automatic loadVectors();
		int ptr;
		int words;
		int gapBits;
		int totalWords;
		ptr = 1;
		totalWords = 0;
		$readmemh("tb/serviceProtocolVectors.txt", vectors);
		testCount = int'(vectors[0]);
		if (testCount > MAX_TESTS)
			testCount = 0;
		for (int t = 0; t < testCount; t++) begin
			testBase[t] = ptr;
			gapBits = int'(vectors[ptr + 1]);
			words = int'(vectors[ptr + 2]);
			gapCycles[t] = 0;
			for (int b = 0; b < gapBits; b++) begin
				lfsr = lfsrStep(lfsr);
				gapCycles[t] = (gapCycles[t] << 1) | int'(lfsr[0]);
			end
			totalWords += words;
			ptr += 3 + words + 5;
		end
		watchdogCycles = totalWords + 8 * testCount;
	endtask

	task automatic driveTests();
		logic [19:0] entry;
		int          words;
		for (int t = 0; t < testCount; t++) begin
			words = int'(vectors[testBase[t] + 2]);
			repeat (gapCycles[t]) begin
				@(negedge clk);
				enable = 1'b1;
				wordValid = 1'b0;
			end
			for (int i = 0; i < words; i++) begin
				entry = vectors[testBase[t] + 3 + i];
				@(negedge clk);
				// Flag low is a cycle with enable dropped and no word.
				enable = entry[16];
				wordValid = entry[16];
				word = entry[15:0];
			end
		end
		@(negedge clk);
		enable = 1'b1;
		wordValid = 1'b0;
	endtask

	task automatic checkTests();
		TReport      expected;
		logic [15:0] expectedCount;
		int          e;
		int          limit;
		bit          seen;
		bit          reportOk;
		bit          countOk;
		string       name;
		for (int t = 0; t < testCount; t++) begin
			name = testName(vectors[testBase[t]]);
			limit = int'(vectors[testBase[t] + 2]) + gapCycles[t] + 4;
			seen = 1'b0;
			for (int c = 0; c < limit && !seen; c++) begin
				@(negedge clk);
				seen = (reportValid === 1'b1);
			end
			if (!seen) begin
				$display("test %s: no report arrived within %0d cycles", name, limit);
				failCount++;
				return;
			end
			e = testBase[t] + 3 + int'(vectors[testBase[t] + 2]);
			expected.addr = vectors[e][7:0];
			expected.num = vectors[e + 1][15:0];
			expected.status = TPacketStatus'(vectors[e + 2][1:0]);
			expected.regSum = vectors[e + 3][15:0];
			expectedCount = vectors[e + 4][15:0];
			compareReport(name, expected, report, reportOk);
			compareCount(name, expectedCount, errCount, countOk);
			if (reportOk && countOk) begin
				passCount++;
				$display("test %s: ok", name);
			end else begin
				failCount++;
				$display("test %s: error", name);
			end
		end
	endtask

	initial begin
		wait (watchdogCycles > 0);
		#(watchdogCycles * CLOCK_PERIOD);
		$display("Timeout after %0d cycles, the DUT stopped producing reports", watchdogCycles);
		$display("Regression failed");
		$finish;
	end

	initial begin
		rstN = 1'b0;
		enable = 1'b0;
		wordValid = 1'b0;
		word = '0;
		passCount = 0;
		failCount = 0;
		lfsr = 32'h1114;
		loadVectors();
		repeat (2) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
		fork
			driveTests();
			checkTests();
		join
		$display("tests %0d, passed %0d, failed %0d", testCount, passCount, failCount);
		if (testCount > 0 && failCount == 0 && passCount == testCount)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb/serviceProtocolVectors.txt
// Per test: name index, gap bits, entry count, entries {enable flag, word}, then
// expected addr, num, status, regSum and errCount. The first value is the test count.
C
// WRITE, ADD and CLEAR on endpoint 1.
0 2 8 10001 10401 11111 12222 13333 14444 1AEAC 10010 01 0010 0 AAAA 0000
1 2 6 10001 10202 10100 10200 10503 10011 01 0011 0 ADAA 0000
2 2 4 10001 10003 10004 10012 01 0012 0 0000 0000
// Bad checksum leaves the registers alone.
3 2 6 10001 10201 10005 10007 1020E 10013 01 0013 0 000C 0000
4 2 5 10001 10101 19999 11234 10014 01 0014 1 000C 0001
// Address 7 has no endpoint, endpoint 2 follows.
5 2 5 10007 10101 100AA 101B2 10015 07 0015 3 0000 0002
6 2 7 10002 10301 10100 10020 10003 10426 10016 02 0016 0 0123 0002
// Unknown opcode 55, then enable low for two cycles.
7 2 4 10001 10155 00077 00000 01 0000 2 000C 0003
8 2 5 10001 10102 10001 10104 10017 01 0017 0 000D 0003
// Back-to-back packets with no idle cycles.
9 0 8 10003 10401 10001 10002 10003 10004 1040E 10020 03 0020 0 000A 0003
A 0 5 10003 10102 10010 10115 10021 03 0021 0 001A 0003
B 0 4 10000 10003 10003 10022 00 0022 0 0000 0003

// File: serviceProtocolTop.f
+incdir+hdl
hdl/serviceProtocolPkg.sv
hdl/packetDecoder.sv
hdl/commandEndpoint.sv
hdl/responseCollector.sv
hdl/serviceProtocolTop.sv
tb/serviceProtocolTb.sv

// File: Makefile
TOOL      = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = serviceProtocolTb
FILELIST  = serviceProtocolTop.f
BUILD_DIR = obj_dir

.PHONY: sim clean

# Pass only when the pass message shows up in the output.
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "Regression passed"

clean:
	rm -rf $(BUILD_DIR)
